// File: bench/mem_model.sv
// Behavioral line memory with random delay, ready stalls and an insecure region
module mem_model
	import mem_msg_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic memreq_val,
	input  mem_req_t memreq_msg,
	output logic memreq_rdy,
	output logic memresp_val,
	output mem_resp_t memresp_msg,
	output logic insecure,
	input  logic memresp_rdy
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] words [logic [31:0]];
	int req_count = 0;
	mem_req_t last_req;
	logic busy = 1'b0;
	int delay = 0;
	mem_resp_t pending;
	logic pending_insecure = 1'b0;

	initial begin
		memreq_rdy = 1'b0;
		memresp_val = 1'b0;
		memresp_msg = '0;
		insecure = 1'b0;
	end

	// Unwritten words follow the fill pattern
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		if (words.exists(addr))
			return words[addr];
		return addr ^ 32'h5a5a_5a5a;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			memreq_rdy <= 1'b0;
			memresp_val <= 1'b0;
			insecure <= 1'b0;
			busy = 1'b0;
		end else begin
			// Response stays up until it is taken
			if (memresp_rdy) begin
				memresp_val <= 1'b0;
				insecure <= 1'b0;
			end
			memreq_rdy <= ($urandom_range(3) != 0);
			if (memreq_val && memreq_rdy) begin
				req_count = req_count + 1;
				last_req = memreq_msg;
				pending.msg_type = memreq_msg.msg_type;
				pending.opaque = memreq_msg.opaque;
				pending.data = '0;
				if (memreq_msg.msg_type == req_write) begin
					words[memreq_msg.addr] = memreq_msg.data[31:0];
				end else begin
					for (int i = 0; i < 4; i++)
						pending.data[32*i +: 32] = word_at(memreq_msg.addr + 32'(4 * i));
				end
				pending_insecure = memreq_msg.addr[20];
				delay = $urandom_range(5);
				busy = 1'b1;
			end else if (busy) begin
				if (delay == 0) begin
					memresp_val <= 1'b1;
					memresp_msg <= pending;
					insecure <= pending_insecure;
					busy = 1'b0;
				end else begin
					delay = delay - 1;
				end
			end
		end
	end

endmodule

// File: bench/tb_top.sv
// Testbench for the secure cache with reference model, handshake checks and watchdog
module tb_top
	import mem_msg_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int directed_reqs = 24;
	localparam int random_reqs = 40;
	localparam int total_reqs = directed_reqs + random_reqs;

	logic clk;
	logic reset;
	logic procreq_val;
	proc_req_t procreq_msg;
	logic procreq_domain;
	logic procreq_rdy;
	logic procresp_val;
	proc_resp_t procresp_msg;
	logic procresp_rdy;
	logic fail;
	logic memreq_val;
	mem_req_t memreq_msg;
	logic memreq_rdy;
	logic memresp_val;
	mem_resp_t memresp_msg;
	logic insecure;
	logic memresp_rdy;

	int errors = 0;
	int issued = 0;
	logic [7:0] opq = 8'h0;
	logic fail_exp = 1'b0;
	logic in_flight = 1'b0;

	// Reference state
	logic [31:0] ref_mem [logic [31:0]];
	logic [31:0] ref_boundary = 32'h0000_c000;
	logic ref_valid [4] = '{default: 1'b0};
	logic [25:0] ref_tag [4];

	// Handshake hold checks
	logic memreq_stalled = 1'b0;
	logic resp_stalled = 1'b0;
	mem_req_t memreq_prev;
	proc_resp_t resp_prev;

	secure_cache_top DUT (.*);

	mem_model u_mem (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		procresp_rdy <= ($urandom_range(3) != 0);
	end

	initial begin
		#(200 * total_reqs * 8);
		$display("Watchdog expired after %0d requests", issued);
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [31:0] ref_word(input logic [31:0] addr);
		if (ref_mem.exists(addr))
			return ref_mem[addr];
		return addr ^ 32'h5a5a_5a5a;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else begin
			errors++;
			$display("FAIL %s: got %h expected %h", name, got, exp);
		end
	endtask

	// A stalled message must not change before it is taken
	always @(negedge clk) begin
		if (!reset) begin
			// Memory side always ready
			assert (memresp_rdy)
			else begin
				errors++;
				$display("FAIL memresp_rdy: got %h expected %h", memresp_rdy, 1'b1);
			end
			// No new request while one is open
			if (in_flight)
				assert (!procreq_rdy)
				else begin
					errors++;
					$display("FAIL procreq_rdy: got %h expected %h", procreq_rdy, 1'b0);
				end
			if (memreq_stalled)
				assert (memreq_val && memreq_msg == memreq_prev)
				else begin
					errors++;
					$display("FAIL memreq_msg: got %h expected %h", memreq_msg, memreq_prev);
				end
			if (resp_stalled)
				assert (procresp_val && procresp_msg == resp_prev)
				else begin
					errors++;
					$display("FAIL procresp_msg: got %h expected %h", procresp_msg, resp_prev);
				end
			memreq_stalled = memreq_val && !memreq_rdy;
			resp_stalled = procresp_val && !procresp_rdy;
			memreq_prev = memreq_msg;
			resp_prev = procresp_msg;
		end
	end

	// ------------------------------------------------------------
	// One request through to its response
	// ------------------------------------------------------------

	task automatic transact(input logic wr, input logic [31:0] addr, input logic [31:0] data,
			input logic dom);
		proc_req_t m;
		proc_resp_t r;
		logic is_ctrl;
		logic cached;
		logic hit_exp;
		logic insec;
		logic [1:0] idx;
		logic [31:0] exp_data;
		int exp_reqs;
		int count0;
		int lat;
		is_ctrl = (addr == 32'h4);
		cached = (addr != 32'h0) && !is_ctrl && (addr < ref_boundary);
		insec = addr[20];
		idx = addr[5:4];
		hit_exp = cached && ref_valid[idx] && (ref_tag[idx] == addr[31:6]);
		exp_reqs = (is_ctrl || (cached && !wr && hit_exp)) ? 0 : 1;
		exp_data = (wr || is_ctrl || insec) ? 32'h0 : ref_word(addr);
		m.msg_type = req_type_e'(wr);
		m.opaque = opq;
		m.addr = addr;
		m.data = data;
		count0 = u_mem.req_count;
		issued++;
		@(posedge clk);
		procreq_val <= 1'b1;
		procreq_msg <= m;
		procreq_domain <= dom;
		do @(negedge clk); while (!procreq_rdy);
		check_value("fail", 32'(fail), 32'(fail_exp));
		@(posedge clk);
		procreq_val <= 1'b0;
		in_flight = 1'b1;
		@(negedge clk);
		check_value("fail", 32'(fail), 32'h0);
		lat = 0;
		while (!procresp_val) begin
			@(negedge clk);
			lat++;
		end
		if (is_ctrl || (cached && !wr && hit_exp))
			check_value("latency", 32'(lat), 32'd3);
		while (!(procresp_val && procresp_rdy))
			@(negedge clk);
		r = procresp_msg;
		fail_exp = insec && (exp_reqs > 0);
		check_value("procresp_msg.data", r.data, exp_data);
		check_value("procresp_msg.opaque", 32'(r.opaque), 32'(opq));
		check_value("procresp_msg.msg_type", 32'(r.msg_type), 32'(wr));
		check_value("fail", 32'(fail), 32'(fail_exp));
		check_value("memreq count", 32'(u_mem.req_count - count0), 32'(exp_reqs));
		if (exp_reqs > 0) begin
			check_value("memreq_msg.addr", u_mem.last_req.addr,
				wr ? addr : {addr[31:4], 4'h0});
			check_value("memreq_msg.msg_type", 32'(u_mem.last_req.msg_type), 32'(wr));
		end
		@(posedge clk);
		in_flight = 1'b0;
		// Update the reference after the response
		if (is_ctrl && wr && dom)
			ref_boundary = data;
		if (wr && !is_ctrl)
			ref_mem[addr] = data;
		if (cached && !wr && !hit_exp && !insec) begin
			ref_valid[idx] = 1'b1;
			ref_tag[idx] = addr[31:6];
		end
		opq = opq + 8'h1;
	endtask

	initial begin
		logic [31:0] base;
		void'($urandom(32'h0285_5699));
		reset = 1'b1;
		procreq_val = 1'b0;
		procreq_msg = '0;
		procreq_domain = 1'b0;
		procresp_rdy = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		// Direct and control register accesses
		transact(1'b0, 32'h0, 32'h0, 1'b0);
		transact(1'b0, 32'h0, 32'h0, 1'b1);
		transact(1'b1, 32'h4, 32'h100, 1'b0);
		transact(1'b0, 32'h8000, 32'h0, 1'b0);
		transact(1'b0, 32'h8000, 32'h0, 1'b0);
		transact(1'b0, 32'h4, 32'h0, 1'b0);
		transact(1'b1, 32'h4, 32'h4000, 1'b1);
		transact(1'b0, 32'h8000, 32'h0, 1'b0);
		transact(1'b0, 32'h8000, 32'h0, 1'b0);
		transact(1'b0, 32'h2000, 32'h0, 1'b1);
		transact(1'b0, 32'h2000, 32'h0, 1'b1);
		// Write-through, cached and uncached
		transact(1'b1, 32'h2004, 32'hdead_beef, 1'b0);
		transact(1'b0, 32'h2004, 32'h0, 1'b0);
		transact(1'b1, 32'h9000, 32'h1234_5678, 1'b0);
		transact(1'b0, 32'h9000, 32'h0, 1'b0);
		transact(1'b1, 32'h3008, 32'hcafe_f00d, 1'b1);
		transact(1'b0, 32'h3008, 32'h0, 1'b1);
		// Insecure region
		transact(1'b0, 32'h0010_0000, 32'h0, 1'b0);
		transact(1'b1, 32'h4, 32'h0020_0000, 1'b1);
		transact(1'b0, 32'h0010_0010, 32'h0, 1'b0);
		transact(1'b0, 32'h0010_0010, 32'h0, 1'b0);
		transact(1'b1, 32'h4, 32'h0000_c000, 1'b1);
		// Reads exactly at the boundary stay uncached
		transact(1'b0, 32'h0000_c000, 32'h0, 1'b0);
		transact(1'b0, 32'h0000_c000, 32'h0, 1'b0);
		// Random mix with conflicting tags
		for (int i = 0; i < random_reqs; i++) begin
			case ($urandom_range(2))
				0: base = 32'h100;
				1: base = 32'h1100;
				default: base = 32'hc100;
			endcase
			transact(1'($urandom_range(1)), base + ($urandom_range(63) << 2), $urandom,
				1'($urandom_range(1)));
		end
		repeat (4) @(posedge clk);
		$display("Done: %0d requests, %0d errors", issued, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: logic/access_ctrl.sv
// Blocking controller FSM with request latch and memory request widening
`include "cache_defs.svh"

module access_ctrl
	import mem_msg_pkg::*, ctrl_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic procreq_val,
	input  proc_req_t procreq_msg,
	input  logic procreq_domain,
	output logic procreq_rdy,
	input  req_class_e req_class,
	input  logic hit,
	output logic memreq_push,
	input  logic memreq_full,
	output mem_req_t memreq_data,
	input  logic memresp_val,
	input  mem_resp_t memresp_msg,
	input  logic insecure,
	output logic resp_push,
	input  logic resp_full,
	output logic rd_en,
	output logic fill_en,
	output logic write_en,
	output logic boundary_we,
	output proc_req_t req,
	output logic domain,
	output logic start,
	output logic [`LINE_W-1:0] mem_line,
	output logic mem_insecure
);

	ctrl_state_e state;
	ctrl_state_e state_next;
	logic is_cached;
	logic is_write;
	logic mem_done;

	assign procreq_rdy = (state == st_idle) && !resp_full;
	assign start = procreq_val && procreq_rdy;
	assign is_cached = (req_class == class_cached);
	assign is_write = (req.msg_type == req_write);
	assign mem_done = (state == st_mem_wait) && memresp_val;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			mem_insecure <= 1'b0;
		end else begin
			state <= state_next;
			if (start)
				mem_insecure <= 1'b0;
			else if (mem_done)
				mem_insecure <= insecure;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			req <= procreq_msg;
			domain <= procreq_domain;
		end
		if (mem_done)
			mem_line <= memresp_msg.data;
	end

	// ------------------------------------------------------------
	// Next state and strobes
	// ------------------------------------------------------------

	always_comb begin
		state_next = state;
		rd_en = 1'b0;
		fill_en = 1'b0;
		write_en = 1'b0;
		boundary_we = 1'b0;
		memreq_push = 1'b0;
		resp_push = 1'b0;
		case (state)
			st_idle:
				if (start)
					state_next = st_decode;
			st_decode: begin
				rd_en = is_cached;
				if (req_class == class_direct || req_class == class_uncached)
					state_next = st_mem_req;
				else
					state_next = st_lookup;
			end
			st_lookup: begin
				// Control accesses pass here too, keeping local responses at 3 cycles
				boundary_we = (req_class == class_ctrl_write);
				write_en = is_cached && is_write;
				if (is_cached && (is_write || !hit))
					state_next = st_mem_req;
				else
					state_next = st_respond;
			end
			st_mem_req: begin
				memreq_push = !memreq_full;
				if (!memreq_full)
					state_next = st_mem_wait;
			end
			st_mem_wait:
				if (memresp_val) begin
					if (is_cached && !is_write && !insecure)
						state_next = st_fill;
					else
						state_next = st_respond;
				end
			st_fill: begin
				fill_en = 1'b1;
				state_next = st_respond;
			end
			st_respond: begin
				resp_push = !resp_full;
				if (!resp_full)
					state_next = st_idle;
			end
			default:
				state_next = st_idle;
		endcase
	end

	// Reads fetch the whole line; writes keep the word offset and replicate the word
	always_comb begin
		memreq_data.msg_type = req.msg_type;
		memreq_data.opaque = req.opaque;
		if (is_write)
			memreq_data.addr = {req.addr[`ADDR_W-1:2], 2'b00};
		else
			memreq_data.addr = {req.addr[`ADDR_W-1:4], 4'b0000};
		memreq_data.data = {(`LINE_W / `WORD_W){req.data}};
	end

endmodule

// File: logic/cache_defs.svh
// Width, special address, boundary reset and line store depth macros
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Data path widths
`define ADDR_W 32
`define WORD_W 32
`define LINE_W 128
`define OPQ_W 8

// Line store depth, direct mapped
`define NUM_LINES 4

// Special addresses
`define DIRECT_ADDR 32'h0000_0000
`define CTRL_ADDR 32'h0000_0004

// Cacheable boundary out of reset
`define BOUNDARY_RESET 32'h0000_c000

`endif

// File: logic/ctrl_pkg.sv
// Request class and controller state enums
package ctrl_pkg;

	typedef enum logic [2:0] {
		class_direct      = 3'd0,
		class_ctrl_write  = 3'd1,
		class_ctrl_ignore = 3'd2,
		class_cached      = 3'd3,
		class_uncached    = 3'd4
	} req_class_e;

	typedef enum logic [2:0] {
		st_idle     = 3'd0,
		st_decode   = 3'd1,
		st_lookup   = 3'd2,
		st_mem_req  = 3'd3,
		st_mem_wait = 3'd4,
		st_fill     = 3'd5,
		st_respond  = 3'd6
	} ctrl_state_e;

endpackage

// File: logic/line_store.sv
// Direct-mapped tag, valid and line arrays with registered line read
`include "cache_defs.svh"

module line_store (
	input  logic clk,
	input  logic reset,
	input  logic [`ADDR_W-1:0] addr,
	input  logic rd_en,
	input  logic fill_en,
	input  logic write_en,
	input  logic [`LINE_W-1:0] fill_line,
	input  logic [`WORD_W-1:0] write_word,
	output logic hit,
	output logic [`LINE_W-1:0] rd_line
);

	localparam int OFF_W = $clog2(`LINE_W / 8);
	localparam int IDX_W = $clog2(`NUM_LINES);
	localparam int SEL_W = $clog2(`LINE_W / `WORD_W);
	localparam int TAG_W = `ADDR_W - OFF_W - IDX_W;

	logic [TAG_W-1:0] tags [`NUM_LINES];
	logic [`LINE_W-1:0] lines [`NUM_LINES];
	logic [`NUM_LINES-1:0] valid;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic [SEL_W-1:0] word_sel;

	assign idx = addr[OFF_W+IDX_W-1:OFF_W];
	assign tag = addr[`ADDR_W-1:OFF_W+IDX_W];
	assign word_sel = addr[OFF_W-1:OFF_W-SEL_W];
	assign hit = valid[idx] && (tags[idx] == tag);

	always_ff @(posedge clk) begin
		if (reset)
			valid <= '0;
		else if (fill_en)
			valid[idx] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			tags[idx] <= tag;
			lines[idx] <= fill_line;
		end else if (write_en && hit) begin
			lines[idx][word_sel*`WORD_W +: `WORD_W] <= write_word;
		end
	end

	// Read port also follows a fill so the filled line can be answered from here
	always_ff @(posedge clk) begin
		if (fill_en)
			rd_line <= fill_line;
		else if (rd_en)
			rd_line <= lines[idx];
	end

endmodule

// File: logic/mem_msg_pkg.sv
// Processor and memory request and response message types
`include "cache_defs.svh"

package mem_msg_pkg;

	typedef enum logic {
		req_read  = 1'b0,
		req_write = 1'b1
	} req_type_e;

	// Processor side, one word
	typedef struct packed {
		req_type_e msg_type;
		logic [`OPQ_W-1:0] opaque;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] data;
	} proc_req_t;

	typedef struct packed {
		req_type_e msg_type;
		logic [`OPQ_W-1:0] opaque;
		logic [`WORD_W-1:0] data;
	} proc_resp_t;

	// Memory side, one line
	typedef struct packed {
		req_type_e msg_type;
		logic [`OPQ_W-1:0] opaque;
		logic [`ADDR_W-1:0] addr;
		logic [`LINE_W-1:0] data;
	} mem_req_t;

	typedef struct packed {
		req_type_e msg_type;
		logic [`OPQ_W-1:0] opaque;
		logic [`LINE_W-1:0] data;
	} mem_resp_t;

endpackage

// File: logic/msg_hold.sv
// One-entry val/rdy holding buffer with a type-parameterized payload
module msg_hold #(
	parameter type payload_t = logic [7:0]
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  payload_t push_data,
	output logic full,
	output logic val,
	output payload_t data,
	input  logic rdy
);

	assign full = val;

	always_ff @(posedge clk) begin
		if (reset)
			val <= 1'b0;
		else if (push && !val)
			val <= 1'b1;
		else if (val && rdy)
			val <= 1'b0;
	end

	// Payload only loads while empty
	always_ff @(posedge clk) begin
		if (push && !val)
			data <= push_data;
	end

endmodule

// File: logic/req_decode.sv
// Boundary control register and request classification
`include "cache_defs.svh"

module req_decode
	import mem_msg_pkg::*, ctrl_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  proc_req_t req,
	input  logic domain,
	input  logic boundary_we,
	output req_class_e req_class
);

	logic [`ADDR_W-1:0] boundary;

	always_ff @(posedge clk) begin
		if (reset) begin
			boundary <= `BOUNDARY_RESET;
		end else if (boundary_we) begin
			boundary <= req.data;
		end
	end

	// ------------------------------------------------------------
	// Classification of the latched request
	// ------------------------------------------------------------

	always_comb begin
		if (req.addr == `DIRECT_ADDR) begin
			req_class = class_direct;
		end else if (req.addr == `CTRL_ADDR) begin
			// Only a high domain write may move the boundary
			if (domain && req.msg_type == req_write)
				req_class = class_ctrl_write;
			else
				req_class = class_ctrl_ignore;
		end else if (req.addr < boundary) begin
			req_class = class_cached;
		end else begin
			req_class = class_uncached;
		end
	end

endmodule

// File: logic/resp_build.sv
// Response word selection, data zeroing and sticky fail flag
`include "cache_defs.svh"

module resp_build
	import mem_msg_pkg::*, ctrl_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  proc_req_t req,
	input  req_class_e req_class,
	input  logic [`LINE_W-1:0] hit_line,
	input  logic [`LINE_W-1:0] mem_line,
	input  logic mem_insecure,
	input  logic start,
	output proc_resp_t resp,
	output logic fail
);

	logic [1:0] word_sel;
	logic [`WORD_W-1:0] word;
	logic zero_data;

	assign word_sel = req.addr[3:2];
	assign zero_data = (req_class == class_ctrl_write) || (req_class == class_ctrl_ignore)
		|| (req.msg_type == req_write) || mem_insecure;

	// Cached reads are answered from the line store read port
	always_comb begin
		if (req_class == class_cached)
			word = hit_line[word_sel*`WORD_W +: `WORD_W];
		else
			word = mem_line[word_sel*`WORD_W +: `WORD_W];
		resp.msg_type = req.msg_type;
		resp.opaque = req.opaque;
		resp.data = zero_data ? '0 : word;
	end

	always_ff @(posedge clk) begin
		if (reset || start)
			fail <= 1'b0;
		else if (push && mem_insecure)
			fail <= 1'b1;
	end

endmodule

// File: logic/secure_cache_top.sv
// Top level of the security-aware blocking cache controller
`include "cache_defs.svh"

module secure_cache_top
	import mem_msg_pkg::*, ctrl_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic procreq_val,
	input  proc_req_t procreq_msg,
	input  logic procreq_domain,
	output logic procreq_rdy,
	output logic procresp_val,
	output proc_resp_t procresp_msg,
	input  logic procresp_rdy,
	output logic fail,
	output logic memreq_val,
	output mem_req_t memreq_msg,
	input  logic memreq_rdy,
	input  logic memresp_val,
	input  mem_resp_t memresp_msg,
	input  logic insecure,
	output logic memresp_rdy
);

	proc_req_t req;
	proc_resp_t resp;
	mem_req_t memreq_data;
	req_class_e req_class;
	logic domain;
	logic boundary_we;
	logic hit;
	logic rd_en;
	logic fill_en;
	logic write_en;
	logic memreq_push;
	logic memreq_full;
	logic resp_push;
	logic resp_full;
	logic start;
	logic mem_insecure;
	logic [`LINE_W-1:0] mem_line;
	logic [`LINE_W-1:0] rd_line;

	// Memory responses are never stalled
	assign memresp_rdy = 1'b1;

	req_decode u_decode (
		.clk(clk), .reset(reset), .req(req), .domain(domain),
		.boundary_we(boundary_we), .req_class(req_class)
	);

	line_store u_store (
		.clk(clk), .reset(reset), .addr(req.addr), .rd_en(rd_en),
		.fill_en(fill_en), .write_en(write_en), .fill_line(mem_line),
		.write_word(req.data), .hit(hit), .rd_line(rd_line)
	);

	access_ctrl u_ctrl (
		.clk(clk), .reset(reset), .procreq_val(procreq_val),
		.procreq_msg(procreq_msg), .procreq_domain(procreq_domain),
		.procreq_rdy(procreq_rdy), .req_class(req_class), .hit(hit),
		.memreq_push(memreq_push), .memreq_full(memreq_full), .memreq_data(memreq_data),
		.memresp_val(memresp_val), .memresp_msg(memresp_msg), .insecure(insecure),
		.resp_push(resp_push), .resp_full(resp_full), .rd_en(rd_en),
		.fill_en(fill_en), .write_en(write_en), .boundary_we(boundary_we),
		.req(req), .domain(domain), .start(start), .mem_line(mem_line),
		.mem_insecure(mem_insecure)
	);

	resp_build u_resp (
		.clk(clk), .reset(reset), .push(resp_push), .req(req), .req_class(req_class),
		.hit_line(rd_line), .mem_line(mem_line), .mem_insecure(mem_insecure),
		.start(start), .resp(resp), .fail(fail)
	);

	msg_hold #(.payload_t(mem_req_t)) u_memreq_hold (
		.clk(clk), .reset(reset), .push(memreq_push), .push_data(memreq_data),
		.full(memreq_full), .val(memreq_val), .data(memreq_msg), .rdy(memreq_rdy)
	);

	msg_hold #(.payload_t(proc_resp_t)) u_resp_hold (
		.clk(clk), .reset(reset), .push(resp_push), .push_data(resp),
		.full(resp_full), .val(procresp_val), .data(procresp_msg), .rdy(procresp_rdy)
	);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f sim.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

// File: sim.f
+incdir+logic
logic/mem_msg_pkg.sv
logic/ctrl_pkg.sv
logic/req_decode.sv
logic/line_store.sv
logic/access_ctrl.sv
logic/msg_hold.sv
logic/resp_build.sv
logic/secure_cache_top.sv
bench/mem_model.sv
bench/tb_top.sv
